// File: Bender.yml
package:
  name: noc_itf_ctrl

sources:
  - noc_itf_pkg.sv
  - noc_cfg_if.sv
  - core_rd_cfg_bank.sv
  - dma_rd_cfg_bank.sv
  - cmd_dispatch.sv
  - noc_itf_ctrl.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - tb_noc_itf_ctrl.sv

// File: cmd_dispatch.sv
// one command in flight; core holds cmd_req until cmd_gnt, unused codes never grant
module cmd_dispatch (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      cmd_req,
    input  noc_itf_pkg::cmd_target_e  cmd_addr,
    input  logic                      core_rd_gnt,
    input  logic                      dma_rd_gnt,
    input  logic                      core_rd_done,
    input  logic                      dma_rd_done,
    output logic                      cmd_gnt,
    output logic                      cmd_ok,
    output logic                      core_rd_req,
    output logic                      dma_rd_req
);

    // bit 0 core read, bit 1 DMA read
    logic [noc_itf_pkg::num_chan-1:0] finish_set;
    logic [noc_itf_pkg::num_chan-1:0] finish_status;
    logic [noc_itf_pkg::num_chan-1:0] chan_start;
    logic [noc_itf_pkg::num_chan-1:0] chan_done;
    logic                             fin_match;
    logic                             fin_clr;

    assign fin_match = (finish_status == finish_set);

    // route request out and grant back
    always_comb begin
        core_rd_req = 1'b0;
        dma_rd_req  = 1'b0;
        cmd_gnt     = 1'b0;
        case (cmd_addr)
            noc_itf_pkg::CMD_CORE_RD: begin
                core_rd_req = cmd_req;
                cmd_gnt     = core_rd_gnt;
            end
            noc_itf_pkg::CMD_DMA_RD: begin
                dma_rd_req = cmd_req;
                cmd_gnt    = dma_rd_gnt;
            end
            noc_itf_pkg::CMD_FINISH: begin
                cmd_gnt = fin_match;
            end
            default: ;
        endcase
    end

    // handshakes that start a channel
    assign chan_start = {dma_rd_req & dma_rd_gnt, core_rd_req & core_rd_gnt};
    // simultaneous done pulses all land
    assign chan_done  = {dma_rd_done, core_rd_done};
    // granted finish query
    assign fin_clr    = cmd_req && (cmd_addr == noc_itf_pkg::CMD_FINISH) && fin_match;

    // clear wins over any set in the same cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            finish_set    <= '0;
            finish_status <= '0;
        end else if (fin_clr) begin
            finish_set    <= '0;
            finish_status <= '0;
        end else begin
            finish_set    <= finish_set | chan_start;
            finish_status <= finish_status | chan_done;
        end
    end

    // grant delayed one cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cmd_ok <= 1'b0;
        end else begin
            cmd_ok <= cmd_gnt;
        end
    end

    a_one_chan_req: assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot0({core_rd_req, dma_rd_req})
    );

    a_req_needs_cmd: assert property (
        @(posedge clk) disable iff (!rst_n)
        (core_rd_req || dma_rd_req) |-> cmd_req
    );

endmodule

// File: core_rd_cfg_bank.sv
// core-read config bank; writes to unlisted indices are dropped, target wraps modulo 16
module core_rd_cfg_bank #(
    parameter logic [noc_itf_pkg::node_id_w-1:0] NODE_ID = '0
) (
    input  logic                                     clk,
    input  logic                                     rst_n,
    noc_cfg_if.bank_side                             cfg,
    output logic                                     addr_mode,
    output logic                                     mc,
    output logic                                     dma_transfer,
    output logic                                     pp_en,
    output logic [noc_itf_pkg::node_id_w-1:0]        target_id,
    output logic [1:0][noc_itf_pkg::cfg_data_w-1:0]  base_addr,
    output logic [noc_itf_pkg::pp_num_w-1:0]         pp_num,
    output logic [noc_itf_pkg::cfg_data_w-1:0]       ping_len,
    output logic [noc_itf_pkg::cfg_data_w-1:0]       pong_len,
    output logic                                     local_access,
    output logic                                     irq_en,
    output logic                                     single_fetch
);

    // sign bit plus 4-bit offset
    logic [noc_itf_pkg::node_id_w:0]   rel_addr;
    // absolute target as written
    logic [noc_itf_pkg::node_id_w-1:0] target_abs;
    logic                              wr_en;
    logic                              target_wr;

    assign wr_en     = cfg.valid && (cfg.bank == noc_itf_pkg::CFG_BANK_CORE_RD);
    assign target_wr = wr_en && (cfg.idx == noc_itf_pkg::cr_idx_target_id);

    // register file, only the listed indices are stored
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr_mode    <= 1'b0;
            rel_addr     <= '0;
            mc           <= 1'b0;
            dma_transfer <= 1'b0;
            pp_en        <= 1'b0;
            target_abs   <= '0;
            base_addr    <= '0;
            pp_num       <= '0;
            ping_len     <= '0;
            pong_len     <= '0;
            irq_en       <= noc_itf_pkg::irq_en_rst;
            single_fetch <= 1'b0;
        end else if (wr_en) begin
            case (cfg.idx)
                noc_itf_pkg::cr_idx_addr_mode:    addr_mode    <= cfg.data[0];
                noc_itf_pkg::cr_idx_rel_addr:     rel_addr     <= cfg.data[noc_itf_pkg::node_id_w:0];
                noc_itf_pkg::cr_idx_mc:           mc           <= cfg.data[0];
                noc_itf_pkg::cr_idx_dma_transfer: dma_transfer <= cfg.data[0];
                noc_itf_pkg::cr_idx_pp_en:        pp_en        <= cfg.data[0];
                noc_itf_pkg::cr_idx_target_id:    target_abs   <= cfg.data[noc_itf_pkg::node_id_w-1:0];
                noc_itf_pkg::cr_idx_base0:        base_addr[0] <= cfg.data;
                noc_itf_pkg::cr_idx_base1:        base_addr[1] <= cfg.data;
                noc_itf_pkg::cr_idx_pp_num:       pp_num       <= cfg.data[noc_itf_pkg::pp_num_w-1:0];
                noc_itf_pkg::cr_idx_ping_len:     ping_len     <= cfg.data;
                noc_itf_pkg::cr_idx_pong_len:     pong_len     <= cfg.data;
                noc_itf_pkg::cr_idx_irq_en:       irq_en       <= cfg.data[0];
                noc_itf_pkg::cr_idx_single_fetch: single_fetch <= cfg.data[0];
                default: ;
            endcase
        end
    end

    // relative mode computes the node from NODE_ID
    assign target_id = addr_mode ? noc_itf_pkg::rel_target(NODE_ID, rel_addr) : target_abs;

    // local flag sampled on the target-id write
    // mode, offset and mc are the values held before this write
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            local_access <= 1'b0;
        end else if (target_wr) begin
            local_access <= !mc && (addr_mode ? (rel_addr[noc_itf_pkg::node_id_w-1:0] == '0)
                : (cfg.data[noc_itf_pkg::node_id_w-1:0] == NODE_ID));
        end
    end

    // flag only moves right after a target-id write
    a_local_access_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        $changed(local_access) |-> $past(target_wr)
    );

endmodule

// File: dma_rd_cfg_bank.sv
// DMA-read config bank; relative mode replaces the NoC high part with a 4-bit node id
module dma_rd_cfg_bank #(
    parameter logic [noc_itf_pkg::node_id_w-1:0] NODE_ID = '0
) (
    input  logic                                     clk,
    input  logic                                     rst_n,
    noc_cfg_if.bank_side                             cfg,
    output logic                                     dma_transfer,
    output logic                                     pp_en,
    output logic [1:0][noc_itf_pkg::cfg_data_w-1:0]  ram_base_addr,
    output logic [noc_itf_pkg::noc_addr_w-1:0]       noc_base_addr,
    output logic [noc_itf_pkg::pp_num_w-1:0]         pp_num,
    output logic [noc_itf_pkg::cfg_data_w-1:0]       ping_len,
    output logic [noc_itf_pkg::cfg_data_w-1:0]       pong_len
);

    logic                                 addr_mode;
    logic [noc_itf_pkg::node_id_w:0]      rel_addr;
    logic [noc_itf_pkg::cfg_data_w-1:0]   noc_low;
    logic [noc_itf_pkg::noc_high_w-1:0]   noc_high;
    // high part after mode select
    logic [noc_itf_pkg::noc_high_w-1:0]   noc_high_sel;
    logic                                 wr_en;

    assign wr_en = cfg.valid && (cfg.bank == noc_itf_pkg::CFG_BANK_DMA_RD);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr_mode     <= 1'b0;
            rel_addr      <= '0;
            dma_transfer  <= 1'b0;
            pp_en         <= 1'b0;
            ram_base_addr <= '0;
            noc_low       <= '0;
            noc_high      <= '0;
            pp_num        <= '0;
            ping_len      <= '0;
            pong_len      <= '0;
        end else if (wr_en) begin
            case (cfg.idx)
                noc_itf_pkg::dr_idx_addr_mode:    addr_mode        <= cfg.data[0];
                noc_itf_pkg::dr_idx_rel_addr:     rel_addr         <= cfg.data[noc_itf_pkg::node_id_w:0];
                noc_itf_pkg::dr_idx_dma_transfer: dma_transfer     <= cfg.data[0];
                noc_itf_pkg::dr_idx_pp_en:        pp_en            <= cfg.data[0];
                noc_itf_pkg::dr_idx_ram_base0:    ram_base_addr[0] <= cfg.data;
                noc_itf_pkg::dr_idx_ram_base1:    ram_base_addr[1] <= cfg.data;
                noc_itf_pkg::dr_idx_noc_low:      noc_low          <= cfg.data;
                noc_itf_pkg::dr_idx_noc_high:     noc_high         <= cfg.data[noc_itf_pkg::noc_high_w-1:0];
                noc_itf_pkg::dr_idx_pp_num:       pp_num           <= cfg.data[noc_itf_pkg::pp_num_w-1:0];
                noc_itf_pkg::dr_idx_ping_len:     ping_len         <= cfg.data;
                noc_itf_pkg::dr_idx_pong_len:     pong_len         <= cfg.data;
                default: ;
            endcase
        end
    end

    // relative mode: computed node id, zero extended
    assign noc_high_sel = addr_mode
        ? {{(noc_itf_pkg::noc_high_w - noc_itf_pkg::node_id_w){1'b0}},
           noc_itf_pkg::rel_target(NODE_ID, rel_addr)}
        : noc_high;

    // high part on top, low register below
    assign noc_base_addr = {noc_high_sel, noc_low};

    // upper node bits stay clear while relative
    a_rel_high_zero: assert property (
        @(posedge clk) disable iff (!rst_n)
        addr_mode |-> (noc_base_addr[noc_itf_pkg::noc_addr_w-1 -:
            (noc_itf_pkg::noc_high_w - noc_itf_pkg::node_id_w)] == '0)
    );

endmodule

// File: noc_cfg_if.sv
// single-cycle config write strobe, no handshake; each bank decodes its own bank code
interface noc_cfg_if;

    // write strobe, one cycle per word
    logic                                  valid;
    // target bank
    noc_itf_pkg::cfg_bank_e                bank;
    // register index inside the bank
    logic [noc_itf_pkg::cfg_idx_w-1:0]     idx;
    // write data
    logic [noc_itf_pkg::cfg_data_w-1:0]    data;

    // banks only listen
    modport bank_side (
        input valid,
        input bank,
        input idx,
        input data
    );

endinterface

// File: noc_itf_ctrl.sv
// node interface config and command front end; only core-read and DMA-read channels kept
module noc_itf_ctrl #(
    parameter logic [noc_itf_pkg::node_id_w-1:0] NODE_ID = '0
) (
    input  logic                                     clk,
    input  logic                                     rst_n,
    // config write port
    input  logic [noc_itf_pkg::cfg_idx_w+1:0]        cfg_addr,
    input  logic [noc_itf_pkg::cfg_data_w-1:0]       cfg_data,
    input  logic                                     cfg_valid,
    // command port
    input  logic                                     cmd_req,
    input  logic [2:0]                               cmd_addr,
    output logic                                     cmd_gnt,
    output logic                                     cmd_ok,
    // channel handshakes
    output logic                                     core_rd_req,
    input  logic                                     core_rd_gnt,
    input  logic                                     core_rd_done,
    output logic                                     dma_rd_req,
    input  logic                                     dma_rd_gnt,
    input  logic                                     dma_rd_done,
    // core-read fields
    output logic                                     cr_addr_mode,
    output logic                                     cr_mc,
    output logic                                     cr_dma_transfer,
    output logic                                     cr_pp_en,
    output logic [noc_itf_pkg::node_id_w-1:0]        cr_target_id,
    output logic [1:0][noc_itf_pkg::cfg_data_w-1:0]  cr_base_addr,
    output logic [noc_itf_pkg::pp_num_w-1:0]         cr_pp_num,
    output logic [noc_itf_pkg::cfg_data_w-1:0]       cr_ping_len,
    output logic [noc_itf_pkg::cfg_data_w-1:0]       cr_pong_len,
    output logic                                     cr_local_access,
    output logic                                     itf_irq_en,
    output logic                                     itf_single_fetch,
    // DMA-read fields
    output logic                                     dr_dma_transfer,
    output logic                                     dr_pp_en,
    output logic [1:0][noc_itf_pkg::cfg_data_w-1:0]  dr_ram_base_addr,
    output logic [noc_itf_pkg::noc_addr_w-1:0]       dr_noc_base_addr,
    output logic [noc_itf_pkg::pp_num_w-1:0]         dr_pp_num,
    output logic [noc_itf_pkg::cfg_data_w-1:0]       dr_ping_len,
    output logic [noc_itf_pkg::cfg_data_w-1:0]       dr_pong_len
);

    noc_cfg_if cfg_bus ();

    // address split: top two bits bank, low five bits index
    assign cfg_bus.valid = cfg_valid;
    assign cfg_bus.bank  = noc_itf_pkg::cfg_bank_e'(cfg_addr[noc_itf_pkg::cfg_idx_w +: 2]);
    assign cfg_bus.idx   = cfg_addr[noc_itf_pkg::cfg_idx_w-1:0];
    assign cfg_bus.data  = cfg_data;

    core_rd_cfg_bank #(
        .NODE_ID (NODE_ID)
    ) u_core_rd_bank (
        .clk          (clk),
        .rst_n        (rst_n),
        .cfg          (cfg_bus.bank_side),
        .addr_mode    (cr_addr_mode),
        .mc           (cr_mc),
        .dma_transfer (cr_dma_transfer),
        .pp_en        (cr_pp_en),
        .target_id    (cr_target_id),
        .base_addr    (cr_base_addr),
        .pp_num       (cr_pp_num),
        .ping_len     (cr_ping_len),
        .pong_len     (cr_pong_len),
        .local_access (cr_local_access),
        .irq_en       (itf_irq_en),
        .single_fetch (itf_single_fetch)
    );

    dma_rd_cfg_bank #(
        .NODE_ID (NODE_ID)
    ) u_dma_rd_bank (
        .clk           (clk),
        .rst_n         (rst_n),
        .cfg           (cfg_bus.bank_side),
        .dma_transfer  (dr_dma_transfer),
        .pp_en         (dr_pp_en),
        .ram_base_addr (dr_ram_base_addr),
        .noc_base_addr (dr_noc_base_addr),
        .pp_num        (dr_pp_num),
        .ping_len      (dr_ping_len),
        .pong_len      (dr_pong_len)
    );

    // raw 3-bit code mapped onto the target enum
    cmd_dispatch u_cmd_dispatch (
        .clk          (clk),
        .rst_n        (rst_n),
        .cmd_req      (cmd_req),
        .cmd_addr     (noc_itf_pkg::cmd_target_e'(cmd_addr)),
        .core_rd_gnt  (core_rd_gnt),
        .dma_rd_gnt   (dma_rd_gnt),
        .core_rd_done (core_rd_done),
        .dma_rd_done  (dma_rd_done),
        .cmd_gnt      (cmd_gnt),
        .cmd_ok       (cmd_ok),
        .core_rd_req  (core_rd_req),
        .dma_rd_req   (dma_rd_req)
    );

endmodule

// File: noc_itf_pkg.sv
// shared widths, codes and register map; only core-read and DMA-read banks exist, other codes unused
package noc_itf_pkg;

    // configuration word and register index
    localparam int cfg_data_w = 13;
    localparam int cfg_idx_w  = 5;

    // node id and address fields
    localparam int node_id_w  = 4;
    localparam int pp_num_w   = 11;
    localparam int noc_high_w = 12;
    localparam int noc_addr_w = 25;

    // channels tracked by the finish logic
    localparam int num_chan = 2;

    // bank select from cfg address bits 6:5
    typedef enum logic [1:0] {
        CFG_BANK_CORE_RD = 2'd0,
        CFG_BANK_DMA_RD  = 2'd2
    } cfg_bank_e;

    // command targets on cmd_addr
    typedef enum logic [2:0] {
        CMD_CORE_RD = 3'd0,
        CMD_DMA_RD  = 3'd2,
        CMD_FINISH  = 3'd4
    } cmd_target_e;

    // core-read register map
    localparam logic [cfg_idx_w-1:0] cr_idx_addr_mode    = 5'd0;
    localparam logic [cfg_idx_w-1:0] cr_idx_rel_addr     = 5'd1;
    localparam logic [cfg_idx_w-1:0] cr_idx_mc           = 5'd2;
    localparam logic [cfg_idx_w-1:0] cr_idx_dma_transfer = 5'd3;
    localparam logic [cfg_idx_w-1:0] cr_idx_pp_en        = 5'd4;
    localparam logic [cfg_idx_w-1:0] cr_idx_target_id    = 5'd5;
    localparam logic [cfg_idx_w-1:0] cr_idx_base0        = 5'd6;
    localparam logic [cfg_idx_w-1:0] cr_idx_base1        = 5'd7;
    localparam logic [cfg_idx_w-1:0] cr_idx_pp_num       = 5'd16;
    localparam logic [cfg_idx_w-1:0] cr_idx_ping_len     = 5'd17;
    localparam logic [cfg_idx_w-1:0] cr_idx_pong_len     = 5'd18;
    localparam logic [cfg_idx_w-1:0] cr_idx_irq_en       = 5'd30;
    localparam logic [cfg_idx_w-1:0] cr_idx_single_fetch = 5'd31;

    // DMA-read register map
    localparam logic [cfg_idx_w-1:0] dr_idx_addr_mode    = 5'd0;
    localparam logic [cfg_idx_w-1:0] dr_idx_rel_addr     = 5'd1;
    localparam logic [cfg_idx_w-1:0] dr_idx_dma_transfer = 5'd2;
    localparam logic [cfg_idx_w-1:0] dr_idx_pp_en        = 5'd3;
    localparam logic [cfg_idx_w-1:0] dr_idx_ram_base0    = 5'd4;
    localparam logic [cfg_idx_w-1:0] dr_idx_ram_base1    = 5'd5;
    localparam logic [cfg_idx_w-1:0] dr_idx_noc_low      = 5'd6;
    localparam logic [cfg_idx_w-1:0] dr_idx_noc_high     = 5'd7;
    localparam logic [cfg_idx_w-1:0] dr_idx_pp_num       = 5'd16;
    localparam logic [cfg_idx_w-1:0] dr_idx_ping_len     = 5'd17;
    localparam logic [cfg_idx_w-1:0] dr_idx_pong_len     = 5'd18;

    // sleep interrupt accepted out of reset
    localparam logic irq_en_rst = 1'b1;

    // relative target, bit 4 of rel selects subtract, wraps mod 16
    function automatic logic [node_id_w-1:0] rel_target(
        input logic [node_id_w-1:0] node_id,
        input logic [node_id_w:0]   rel
    );
        return rel[node_id_w] ? node_id - rel[node_id_w-1:0]
                              : node_id + rel[node_id_w-1:0];
    endfunction

endpackage

// File: project.f
noc_itf_pkg.sv
noc_cfg_if.sv
core_rd_cfg_bank.sv
dma_rd_cfg_bank.sv
cmd_dispatch.sv
noc_itf_ctrl.sv
tb_clk_gen.sv
tb_noc_itf_ctrl.sv

// File: tb_clk_gen.sv
// 10 ns clock from time zero; rst_n held low for 5 rising edges, released on a falling edge
module tb_clk_gen (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int half_period = 5;
    localparam int rst_cycles  = 5;

    // free running clock
    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    // release away from the rising edge
    initial begin
        rst_n = 1'b0;
        repeat (rst_cycles) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

// File: tb_noc_itf_ctrl.sv
// DUT built with NODE_ID 5 and checked by concurrent assertions against a shadow model outside reset
module tb_noc_itf_ctrl;
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [3:0]  node_id   = 4'd5;
    // bit n set when index n is stored in that bank
    localparam logic [31:0] cr_listed = 32'hc007_00ff;
    localparam logic [31:0] dr_listed = 32'h0007_00ff;
    // two cycles per config write plus a command phase bounded by stall and timeout limits
    localparam int cfg_cycles  = (4 * 32 + 40 + 24) * 2;
    localparam int cmd_cycles  = 80;
    localparam int test_cycles = 5 + cfg_cycles + cmd_cycles;

    logic                clk;
    logic                rst_n;
    logic [6:0]          cfg_addr;
    logic [12:0]         cfg_data;
    logic                cfg_valid;
    logic                cmd_req;
    logic [2:0]          cmd_addr;
    logic                core_rd_gnt;
    logic                dma_rd_gnt;
    logic                core_rd_done;
    logic                dma_rd_done;
    logic                cmd_gnt;
    logic                cmd_ok;
    logic                core_rd_req;
    logic                dma_rd_req;
    logic                cr_addr_mode;
    logic                cr_mc;
    logic                cr_dma_transfer;
    logic                cr_pp_en;
    logic [3:0]          cr_target_id;
    logic [1:0][12:0]    cr_base_addr;
    logic [10:0]         cr_pp_num;
    logic [12:0]         cr_ping_len;
    logic [12:0]         cr_pong_len;
    logic                cr_local_access;
    logic                itf_irq_en;
    logic                itf_single_fetch;
    logic                dr_dma_transfer;
    logic                dr_pp_en;
    logic [1:0][12:0]    dr_ram_base_addr;
    logic [24:0]         dr_noc_base_addr;
    logic [10:0]         dr_pp_num;
    logic [12:0]         dr_ping_len;
    logic [12:0]         dr_pong_len;

    // shadow model
    logic [12:0]         cr_reg [32];
    logic [12:0]         dr_reg [32];
    logic                local_exp;
    logic [1:0]          fin_set_exp;
    logic [1:0]          fin_stat_exp;
    logic                ok_exp;
    logic                gnt_exp;
    logic                fin_clear;
    logic [1:0]          start_bits;
    logic [3:0]          tgt_exp;
    logic [24:0]         noc_exp;
    logic [68:0]         cr_exp;
    logic [68:0]         cr_act;
    logic [64:0]         dr_exp;
    logic [64:0]         dr_act;
    int                  errors;
    int                  timeouts;
    integer              seed;
    logic                first_core;

    tb_clk_gen clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    noc_itf_ctrl #(
        .NODE_ID (node_id)
    ) uut (.*);

    // bit 4 set means NODE_ID minus offset modulo 16
    function automatic logic [3:0] rel_node_target(input logic [4:0] rel);
        return rel[4] ? node_id - rel[3:0] : node_id + rel[3:0];
    endfunction

    task automatic report_mismatch(input string name, input logic [95:0] exp_val,
                                   input logic [95:0] act_val);
        errors++;
        $display("FAILED at %0t: %s expected %0h, got %0h", $time, name, exp_val, act_val);
    endtask

    // expected grant per command code
    always_comb begin
        case (cmd_addr)
            3'd0:    gnt_exp = core_rd_gnt;
            3'd2:    gnt_exp = dma_rd_gnt;
            3'd4:    gnt_exp = (fin_stat_exp == fin_set_exp);
            default: gnt_exp = 1'b0;
        endcase
    end

    assign fin_clear  = cmd_req && (cmd_addr == 3'd4) && (fin_stat_exp == fin_set_exp);
    assign start_bits = {cmd_req && (cmd_addr == 3'd2) && dma_rd_gnt,
                         cmd_req && (cmd_addr == 3'd0) && core_rd_gnt};

    // register model updates on the same edge as the DUT
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                cr_reg[i] <= '0;
                dr_reg[i] <= '0;
            end
            // irq enable comes up set
            cr_reg[30]   <= 13'd1;
            local_exp    <= 1'b0;
            fin_set_exp  <= '0;
            fin_stat_exp <= '0;
            ok_exp       <= 1'b0;
        end else begin
            if (cfg_valid && cfg_addr[6:5] == 2'd0 && cr_listed[cfg_addr[4:0]])
                cr_reg[cfg_addr[4:0]] <= cfg_data;
            if (cfg_valid && cfg_addr[6:5] == 2'd2 && dr_listed[cfg_addr[4:0]])
                dr_reg[cfg_addr[4:0]] <= cfg_data;
            // local flag uses mode, offset and mc from before this edge
            if (cfg_valid && cfg_addr == {2'd0, 5'd5})
                local_exp <= !cr_reg[2][0] && (cr_reg[0][0] ? (cr_reg[1][3:0] == 4'd0)
                                                            : (cfg_data[3:0] == node_id));
            if (fin_clear) begin
                fin_set_exp  <= '0;
                fin_stat_exp <= '0;
            end else begin
                fin_set_exp  <= fin_set_exp | start_bits;
                fin_stat_exp <= fin_stat_exp | {dma_rd_done, core_rd_done};
            end
            ok_exp <= gnt_exp;
        end
    end

    assign tgt_exp = cr_reg[0][0] ? rel_node_target(cr_reg[1][4:0]) : cr_reg[5][3:0];
    assign cr_exp  = {cr_reg[0][0], cr_reg[2][0], cr_reg[3][0], cr_reg[4][0], cr_reg[7],
                      cr_reg[6], cr_reg[16][10:0], cr_reg[17], cr_reg[18], cr_reg[30][0],
                      cr_reg[31][0]};
    assign cr_act  = {cr_addr_mode, cr_mc, cr_dma_transfer, cr_pp_en, cr_base_addr,
                      cr_pp_num, cr_ping_len, cr_pong_len, itf_irq_en, itf_single_fetch};
    assign dr_exp  = {dr_reg[2][0], dr_reg[3][0], dr_reg[5], dr_reg[4], dr_reg[16][10:0],
                      dr_reg[17], dr_reg[18]};
    assign dr_act  = {dr_dma_transfer, dr_pp_en, dr_ram_base_addr, dr_pp_num,
                      dr_ping_len, dr_pong_len};
    // high part is node id in relative mode and the stored high register otherwise
    assign noc_exp = {dr_reg[0][0] ? {8'd0, rel_node_target(dr_reg[1][4:0])} : dr_reg[7][11:0],
                      dr_reg[6]};

    a_cr_fields: assert property (@(posedge clk) disable iff (!rst_n) cr_act == cr_exp)
        else report_mismatch("core-read fields", $sampled(cr_exp), $sampled(cr_act));
    a_cr_target: assert property (@(posedge clk) disable iff (!rst_n) cr_target_id == tgt_exp)
        else report_mismatch("cr_target_id", $sampled(tgt_exp), $sampled(cr_target_id));
    a_cr_local: assert property (@(posedge clk) disable iff (!rst_n) cr_local_access == local_exp)
        else report_mismatch("cr_local_access", $sampled(local_exp), $sampled(cr_local_access));
    a_dr_fields: assert property (@(posedge clk) disable iff (!rst_n) dr_act == dr_exp)
        else report_mismatch("DMA-read fields", $sampled(dr_exp), $sampled(dr_act));
    a_dr_noc: assert property (@(posedge clk) disable iff (!rst_n) dr_noc_base_addr == noc_exp)
        else report_mismatch("dr_noc_base_addr", $sampled(noc_exp), $sampled(dr_noc_base_addr));
    a_cmd_gnt: assert property (@(posedge clk) disable iff (!rst_n) cmd_gnt == gnt_exp)
        else report_mismatch("cmd_gnt", $sampled(gnt_exp), $sampled(cmd_gnt));
    a_cmd_ok: assert property (@(posedge clk) disable iff (!rst_n) cmd_ok == ok_exp)
        else report_mismatch("cmd_ok", $sampled(ok_exp), $sampled(cmd_ok));
    a_core_req: assert property (@(posedge clk) disable iff (!rst_n)
        core_rd_req == (cmd_req && cmd_addr == 3'd0))
        else report_mismatch("core_rd_req", $sampled(cmd_req && cmd_addr == 3'd0),
                             $sampled(core_rd_req));
    a_dma_req: assert property (@(posedge clk) disable iff (!rst_n)
        dma_rd_req == (cmd_req && cmd_addr == 3'd2))
        else report_mismatch("dma_rd_req", $sampled(cmd_req && cmd_addr == 3'd2),
                             $sampled(dma_rd_req));

    // one write strobe followed by an idle cycle
    task automatic cfg_write(input logic [6:0] addr, input logic [12:0] data);
        @(negedge clk);
        cfg_valid = 1'b1;
        cfg_addr  = addr;
        cfg_data  = data;
        @(negedge clk);
        cfg_valid = 1'b0;
    endtask

    // returns on the rising edge that carries the grant
    task automatic wait_grant(input logic [2:0] code);
        int n;
        n = 0;
        @(posedge clk);
        while (!cmd_gnt && n < 20) begin
            @(posedge clk);
            n++;
        end
        if (!cmd_gnt) begin
            timeouts++;
            $display("command %0d got no grant within 20 cycles at %0t", code, $time);
        end
    endtask

    // channel command stalled while only the other channel grants
    task automatic start_chan(input logic [2:0] code, input int stall);
        @(negedge clk);
        cmd_req     = 1'b1;
        cmd_addr    = code;
        core_rd_gnt = (code != 3'd0);
        dma_rd_gnt  = (code == 3'd0);
        repeat (stall) @(negedge clk);
        core_rd_gnt = (code == 3'd0);
        dma_rd_gnt  = (code != 3'd0);
        wait_grant(code);
        @(negedge clk);
        cmd_req     = 1'b0;
        core_rd_gnt = 1'b0;
        dma_rd_gnt  = 1'b0;
    endtask

    task automatic query_finish();
        @(negedge clk);
        cmd_req  = 1'b1;
        cmd_addr = 3'd4;
        wait_grant(3'd4);
        @(negedge clk);
        cmd_req = 1'b0;
    endtask

    // both channels grant but an unused code must not
    task automatic try_unused(input logic [2:0] code);
        @(negedge clk);
        cmd_req     = 1'b1;
        cmd_addr    = code;
        core_rd_gnt = 1'b1;
        dma_rd_gnt  = 1'b1;
        repeat (3) @(negedge clk);
        cmd_req     = 1'b0;
        core_rd_gnt = 1'b0;
        dma_rd_gnt  = 1'b0;
    endtask

    task automatic pulse_done(input logic core, input logic dma);
        @(negedge clk);
        core_rd_done = core;
        dma_rd_done  = dma;
        @(negedge clk);
        core_rd_done = 1'b0;
        dma_rd_done  = 1'b0;
    endtask

    initial begin
        #(2 * test_cycles * 10);
        $display("watchdog expired after %0d cycles, run stopped", 2 * test_cycles);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        seed         = 32'h891c;
        errors       = 0;
        timeouts     = 0;
        cfg_addr     = '0;
        cfg_data     = '0;
        cfg_valid    = 1'b0;
        cmd_req      = 1'b0;
        cmd_addr     = 3'd1;
        core_rd_gnt  = 1'b0;
        dma_rd_gnt   = 1'b0;
        core_rd_done = 1'b0;
        dma_rd_done  = 1'b0;
        @(posedge rst_n);
        // every index of every bank including the unused banks
        for (int b = 0; b < 4; b++) begin
            for (int i = 0; i < 32; i++) begin
                cfg_write(7'(b * 32 + i), 13'($random(seed)));
            end
        end
        repeat (40) cfg_write(7'($random(seed)), 13'($random(seed)));
        // mc off with absolute match then mismatch
        cfg_write(7'd2, 13'd0);
        cfg_write(7'd0, 13'd0);
        cfg_write(7'd5, 13'(node_id));
        cfg_write(7'd5, 13'(node_id + 4'd3));
        // relative zero offset with subtract and nonzero offsets both ways
        cfg_write(7'd0, 13'd1);
        cfg_write(7'd1, 13'h10);
        cfg_write(7'd5, 13'h7);
        cfg_write(7'd1, 13'h13);
        cfg_write(7'd5, 13'h7);
        cfg_write(7'd1, 13'h0e);
        cfg_write(7'd5, 13'h7);
        // multicast on blocks both hits
        cfg_write(7'd2, 13'd1);
        cfg_write(7'd1, 13'd0);
        cfg_write(7'd5, 13'd0);
        cfg_write(7'd0, 13'd0);
        cfg_write(7'd5, 13'(node_id));
        // DMA high part in absolute then relative mode with wrap
        cfg_write({2'd2, 5'd7}, 13'hfff);
        cfg_write({2'd2, 5'd0}, 13'd1);
        cfg_write({2'd2, 5'd1}, 13'h1c);
        cfg_write({2'd2, 5'd1}, 13'h0b);
        cfg_write({2'd2, 5'd0}, 13'd0);
        // both started and the query held while dones arrive one at a time
        start_chan(3'd0, $unsigned($random(seed)) % 4);
        start_chan(3'd2, $unsigned($random(seed)) % 4);
        first_core = 1'($random(seed));
        @(negedge clk);
        cmd_req  = 1'b1;
        cmd_addr = 3'd4;
        repeat (2) @(negedge clk);
        pulse_done(first_core, !first_core);
        repeat (2) @(negedge clk);
        pulse_done(!first_core, first_core);
        wait_grant(3'd4);
        @(negedge clk);
        cmd_req = 1'b0;
        // cleared vectors grant at once
        query_finish();
        // same-cycle dones
        start_chan(3'd2, 1);
        start_chan(3'd0, 1);
        pulse_done(1'b1, 1'b1);
        query_finish();
        try_unused(3'd1);
        try_unused(3'd3);
        try_unused(3'd5);
        try_unused(3'd6);
        try_unused(3'd7);
        repeat (3) @(negedge clk);
        $display("run complete: %0d value errors, %0d grant timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule
